// File: design/busPkg.sv
package busPkg;

	localparam int NUM_TARGETS = 3;

	// wait counts per target, index 0 is ROM
	localparam logic [NUM_TARGETS-1:0][7:0] DEF_WAITS = {8'd5, 8'd1, 8'd3};

	typedef logic [15:0] word_t;

	typedef struct packed {
		logic [15:0] addr;  // A[23:8]
		logic write;
		word_t wrData;
	} busReq_t;

	// value doubles as the port index
	typedef enum logic [1:0] {
		TGT_ROM,
		TGT_RAM,
		TGT_IO,
		TGT_NONE
	} target_e;

	typedef struct packed {
		target_e target;
		logic vidSnoop;
		logic sndSnoop;
		logic iack;
	} selInfo_t;

	typedef struct packed {
		logic [3:0] index;  // A[11:8]
		logic write;
		word_t wrData;
	} portReq_t;

	typedef struct packed {
		word_t rdData;
		target_e target;
		logic vidSnoop;
		logic sndSnoop;
		logic iack;
		logic err;  // nobody claimed the cycle
	} busResp_t;

	typedef enum logic [1:0] {
		FS_IDLE,
		FS_DECODE,
		FS_WAIT,
		FS_RESP
	} frontState_e;

endpackage

// File: design/cycleFront.sv
module cycleFront import busPkg::*; (
	input logic CLK,
	input logic arstN,
	input busReq_t req,
	input logic reqValid,
	input selInfo_t sel,
	input logic respTaken,
	output logic reqReady,
	output busReq_t curReq,
	output logic cycleActive,
	output logic [NUM_TARGETS-1:0] portStart,
	output portReq_t portReq,
	output logic noneStart,
	output selInfo_t selHeld
);

	frontState_e state;
	frontState_e stateNext;
	logic accept;

	assign accept = (state == FS_IDLE) && reqValid && reqReady;

	always_comb begin
		stateNext = state;
		case (state)
			FS_IDLE: if (accept) stateNext = FS_DECODE;
			FS_DECODE: stateNext = FS_WAIT;  // verdict latched, start goes out
			FS_WAIT: stateNext = FS_RESP;  // start pulse high this cycle
			FS_RESP: if (respTaken) stateNext = FS_IDLE;
			default: stateNext = FS_IDLE;
		endcase
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			state <= FS_IDLE;
			reqReady <= 1'b0;
			portStart <= '0;
			noneStart <= 1'b0;
		end else begin
			state <= stateNext;
			reqReady <= (stateNext == FS_IDLE);  // one cycle in flight
			portStart <= '0;
			noneStart <= 1'b0;
			if (state == FS_DECODE) begin
				if (sel.target == TGT_NONE)
					noneStart <= 1'b1;
				else
					portStart[sel.target] <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) curReq <= req;
		if (state == FS_DECODE) selHeld <= sel;
	end

	assign cycleActive = (state != FS_IDLE);  // address strobe equivalent
	assign portReq = '{index: curReq.addr[3:0], write: curReq.write, wrData: curReq.wrData};

endmodule

// File: design/chipSelect.sv
module chipSelect import busPkg::*; (
	input logic CLK,
	input logic arstN,
	input busReq_t curReq,
	input logic cycleActive,
	output selInfo_t sel
);

	logic overlay;
	logic activeQ;
	logic romWinSeen;
	logic [3:0] region;  // A[23:20]
	logic [7:0] bank;  // A[23:16]
	logic [3:0] page4k;  // A[15:12]
	logic [3:0] page256;  // A[11:8]
	logic rom4x;
	logic romSel;
	logic ramSel;
	logic ioSel;
	logic snoopBank;
	logic vidPage;
	logic sndPage;

	assign region = curReq.addr[15:12];
	assign bank = curReq.addr[15:8];
	assign page4k = curReq.addr[7:4];
	assign page256 = curReq.addr[3:0];

	// boot overlay, cleared once the 4xxxxx window has been used
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			overlay <= 1'b1;
			activeQ <= 1'b0;
			romWinSeen <= 1'b0;
		end else begin
			activeQ <= cycleActive;
			romWinSeen <= cycleActive && rom4x && (sel.target == TGT_ROM);
			if (activeQ && !cycleActive && romWinSeen)
				overlay <= 1'b0;  // strobe just fell
		end
	end

	// region decode
	assign rom4x = (region == 4'h4);
	assign romSel = rom4x || ((region == 4'h0) && overlay);
	assign ramSel = (region[3:2] == 2'b00) && !overlay;
	assign ioSel = (region >= 4'h5) || (rom4x && overlay);

	// ROM wins the 4xxxxx overlap
	always_comb begin
		if (romSel)
			sel.target = TGT_ROM;
		else if (ramSel)
			sel.target = TGT_RAM;
		else if (ioSel)
			sel.target = TGT_IO;
		else
			sel.target = TGT_NONE;
	end

	// snoops only look at RAM writes into the 3Fxxxx bank
	assign snoopBank = ramSel && curReq.write && (bank == 8'h3F);

	always_comb begin
		case (page4k)
			4'h3, 4'h4, 4'h5, 4'h6, 4'hB, 4'hC, 4'hE: vidPage = 1'b1;
			default: vidPage = 1'b0;
		endcase
	end

	assign sndPage = ((page4k == 4'hA) && (page256 inside {[4'h1:4'h3]}))
		|| ((page4k == 4'hF) && (page256 inside {[4'hD:4'hF]}));

	assign sel.vidSnoop = snoopBank && vidPage;
	assign sel.sndSnoop = snoopBank && sndPage;
	assign sel.iack = (bank == 8'hFF);  // interrupt acknowledge space

endmodule

// File: design/targetPort.sv
module targetPort import busPkg::*; #(
	parameter logic [7:0] WAITS = 8'd1,
	parameter bit READ_ONLY = 1'b0
) (
	input logic CLK,
	input logic arstN,
	input logic start,
	input portReq_t preq,
	output logic done,
	output word_t rdData
);

	word_t store [16];
	logic [7:0] cnt;
	logic busy;
	logic expire;

	assign expire = busy && (cnt == 8'd0);

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			busy <= 1'b0;
			cnt <= 8'd0;
			done <= 1'b0;
			for (int i = 0; i < 16; i++)
				store[i] <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				cnt <= WAITS - 8'd1;  // done lands WAITS edges after start
			end else if (expire) begin
				busy <= 1'b0;
				done <= 1'b1;
				if (preq.write && !READ_ONLY)
					store[preq.index] <= preq.wrData;
			end else if (busy) begin
				cnt <= cnt - 8'd1;
			end
		end
	end

	// write cycles answer with zero
	always_ff @(posedge CLK) begin
		if (expire)
			rdData <= preq.write ? '0 : store[preq.index];
	end

endmodule

// File: design/respMerge.sv
module respMerge import busPkg::*; (
	input logic CLK,
	input logic arstN,
	input logic [NUM_TARGETS-1:0] portDone,
	input word_t [NUM_TARGETS-1:0] rdDataArr,
	input logic noneStart,
	input selInfo_t selHeld,
	input logic rspReady,
	output busResp_t rsp,
	output logic rspValid,
	output logic respTaken
);

	word_t doneData;
	logic finish;

	// only one port can finish per bus cycle
	always_comb begin
		doneData = '0;
		for (int i = 0; i < NUM_TARGETS; i++) begin
			if (portDone[i])
				doneData = rdDataArr[i];
		end
	end

	assign finish = (|portDone) || noneStart;
	assign respTaken = rspValid && rspReady;

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN)
			rspValid <= 1'b0;
		else if (finish)
			rspValid <= 1'b1;
		else if (respTaken)
			rspValid <= 1'b0;
	end

	always_ff @(posedge CLK) begin
		if (finish) begin
			rsp.rdData <= noneStart ? '0 : doneData;
			rsp.target <= selHeld.target;
			rsp.vidSnoop <= selHeld.vidSnoop;
			rsp.sndSnoop <= selHeld.sndSnoop;
			rsp.iack <= selHeld.iack;
			rsp.err <= noneStart;  // bus error for unclaimed space
		end
	end

endmodule

// File: design/busGlue.sv
module busGlue import busPkg::*; #(
	parameter logic [NUM_TARGETS-1:0][7:0] WAITS = DEF_WAITS
) (
	input logic CLK,
	input logic arstN,
	input busReq_t req,
	input logic reqValid,
	output logic reqReady,
	output busResp_t rsp,
	output logic rspValid,
	input logic rspReady
);

	busReq_t curReq;
	selInfo_t sel;
	selInfo_t selHeld;
	portReq_t portReq;
	logic cycleActive;
	logic noneStart;
	logic respTaken;
	logic [NUM_TARGETS-1:0] portStart;
	logic [NUM_TARGETS-1:0] portDone;
	word_t [NUM_TARGETS-1:0] rdDataArr;

	cycleFront front (
		.CLK(CLK),
		.arstN(arstN),
		.req(req),
		.reqValid(reqValid),
		.sel(sel),
		.respTaken(respTaken),
		.reqReady(reqReady),
		.curReq(curReq),
		.cycleActive(cycleActive),
		.portStart(portStart),
		.portReq(portReq),
		.noneStart(noneStart),
		.selHeld(selHeld)
	);

	chipSelect decode (
		.CLK(CLK),
		.arstN(arstN),
		.curReq(curReq),
		.cycleActive(cycleActive),
		.sel(sel)
	);

	// port index follows target_e order
	for (genvar g = 0; g < NUM_TARGETS; g++) begin : genPort
		targetPort #(
			.WAITS(WAITS[g]),
			.READ_ONLY(g == int'(TGT_ROM))
		) tgt (
			.CLK(CLK),
			.arstN(arstN),
			.start(portStart[g]),
			.preq(portReq),
			.done(portDone[g]),
			.rdData(rdDataArr[g])
		);
	end

	respMerge merge (
		.CLK(CLK),
		.arstN(arstN),
		.portDone(portDone),
		.rdDataArr(rdDataArr),
		.noneStart(noneStart),
		.selHeld(selHeld),
		.rspReady(rspReady),
		.rsp(rsp),
		.rspValid(rspValid),
		.respTaken(respTaken)
	);

endmodule

// File: test/busGlue_props.sv
module busGlue_props import busPkg::*; (
	input logic CLK,
	input logic arstN,
	input logic reqReady,
	input logic cycleActive,
	input logic [NUM_TARGETS-1:0] portStart,
	input logic rspValid,
	input logic rspReady,
	input busResp_t rsp
);
	timeunit 1ns;
	timeprecision 100ps;

	int assertFails = 0;  // failed assertions so far

	oneStart: assert property (@(posedge CLK) disable iff (!arstN) $onehot0(portStart))
		else begin
			assertFails++;
			$error("more than one port start at once");
		end

	// one cycle in flight
	busyNotReady: assert property (@(posedge CLK) disable iff (!arstN)
		cycleActive |-> !reqReady)
		else begin
			assertFails++;
			$error("reqReady high during an active cycle");
		end

	rspHold: assert property (@(posedge CLK) disable iff (!arstN)
		rspValid && !rspReady |=> rspValid && $stable(rsp))
		else begin
			assertFails++;
			$error("response dropped or changed while stalled");
		end

	quietInReset: assert property (@(posedge CLK) !arstN |=> !reqReady && !rspValid)
		else begin
			assertFails++;
			$error("handshake outputs active in reset");
		end

endmodule

bind busGlue busGlue_props props_i (
	.CLK(CLK),
	.arstN(arstN),
	.reqReady(reqReady),
	.cycleActive(cycleActive),
	.portStart(portStart),
	.rspValid(rspValid),
	.rspReady(rspReady),
	.rsp(rsp)
);

// File: test/busGlue_tb.sv
module busGlue_tb import busPkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT = 200;

	typedef struct {
		string name;
		logic [23:0] addr;
		bit write;
		word_t data;
		int stall;  // rspReady held low this many cycles
	} testVec_t;

	logic CLK;
	logic arstN;
	busReq_t req;
	logic reqValid;
	logic reqReady;
	busResp_t rsp;
	logic rspValid;
	logic rspReady;

	testVec_t tests[$];
	word_t shadow [3][16];  // model copy of each store
	bit overlayOn;
	bit timedOut;
	int passCount;
	int failCount;
	int seed = 32'hb237;

	busGlue #(.WAITS(DEF_WAITS)) dut_i (
		.CLK(CLK),
		.arstN(arstN),
		.req(req),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.rsp(rsp),
		.rspValid(rspValid),
		.rspReady(rspReady)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	task automatic addTest(input string name, input logic [23:0] addr, input bit write,
		input word_t data, input int stall);
		testVec_t v;
		v.name = name;
		v.addr = addr;
		v.write = write;
		v.data = data;
		v.stall = stall;
		tests.push_back(v);
	endtask

	// expected response from the decode rules, then the model state moves on
	task automatic predict(input testVec_t v, output busResp_t exp);
		logic [3:0] region;
		logic [7:0] bank;
		logic [3:0] p4k;
		logic [3:0] p256;
		target_e tgt;
		logic snoopable;
		region = v.addr[23:20];
		bank = v.addr[23:16];
		p4k = v.addr[15:12];
		p256 = v.addr[11:8];
		if (region == 4'h4 || (region == 4'h0 && overlayOn))
			tgt = TGT_ROM;
		else if (region < 4'h4 && !overlayOn)
			tgt = TGT_RAM;
		else if (region >= 4'h5)
			tgt = TGT_IO;
		else
			tgt = TGT_NONE;  // hole under the overlay
		snoopable = (tgt == TGT_RAM) && v.write && (bank == 8'h3F);
		exp.target = tgt;
		exp.err = (tgt == TGT_NONE);
		exp.vidSnoop = snoopable && (p4k inside {4'h3, 4'h4, 4'h5, 4'h6, 4'hB, 4'hC, 4'hE});
		exp.sndSnoop = snoopable && (((p4k == 4'hA) && (p256 >= 4'h1) && (p256 <= 4'h3))
			|| ((p4k == 4'hF) && (p256 >= 4'hD)));
		exp.iack = (bank == 8'hFF);
		exp.rdData = '0;
		if (tgt != TGT_NONE) begin
			if (!v.write)
				exp.rdData = shadow[tgt][p256];
			else if (tgt != TGT_ROM)
				shadow[tgt][p256] = v.data;
		end
		if (region == 4'h4)
			overlayOn = 1'b0;  // first ROM window access ends the overlay
	endtask

	task automatic waitHandshake(input bit forRsp, output bit ok);
		int n = 0;
		ok = 1'b0;
		while (!ok && n < TIMEOUT) begin
			@(negedge CLK);
			ok = forRsp ? rspValid : reqReady;
			n++;
		end
	endtask

	task automatic runTest(input testVec_t v);
		busResp_t exp;
		busResp_t got;
		bit ok;
		bit holdOk = 1'b1;
		predict(v, exp);
		@(posedge CLK);
		req <= '{addr: v.addr[23:8], write: v.write, wrData: v.data};
		reqValid <= 1'b1;
		waitHandshake(1'b0, ok);
		if (!ok) begin
			$display("%s: timed out waiting for reqReady", v.name);
			timedOut = 1'b1;
			failCount++;
			return;
		end
		@(posedge CLK);  // request transfers here
		reqValid <= 1'b0;
		waitHandshake(1'b1, ok);
		if (!ok) begin
			$display("%s: timed out waiting for rspValid", v.name);
			timedOut = 1'b1;
			failCount++;
			return;
		end
		got = rsp;
		repeat (v.stall) begin
			@(negedge CLK);
			if (!rspValid || rsp !== got || reqReady)
				holdOk = 1'b0;
		end
		@(posedge CLK);
		rspReady <= 1'b1;
		@(posedge CLK);  // response transfers here
		rspReady <= 1'b0;
		if (!holdOk) begin
			$display("%s: response not held or a new request was taken while stalled", v.name);
			failCount++;
		end else if (got !== exp) begin
			$display("FAILED %s expected %h actual %h", v.name, exp, got);
			failCount++;
		end else begin
			$display("passed %s", v.name);
			passCount++;
		end
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] d;
		logic [23:0] a;
		arstN = 1'b0;
		req = '0;
		reqValid = 1'b0;
		rspReady = 1'b0;
		overlayOn = 1'b1;
		timedOut = 1'b0;
		passCount = 0;
		failCount = 0;
		for (int t = 0; t < 3; t++)
			for (int i = 0; i < 16; i++)
				shadow[t][i] = '0;

		addTest("ovlLowRom", 24'h000100, 1'b0, 16'h0, 0);
		addTest("ovlHole", 24'h200000, 1'b0, 16'h0, 0);
		addTest("romWindow", 24'h400000, 1'b0, 16'h0, 2);
		addTest("lowRam", 24'h000100, 1'b0, 16'h0, 0);
		addTest("midRam", 24'h200000, 1'b0, 16'h0, 0);
		addTest("ramWrite", 24'h000500, 1'b1, 16'hA5A5, 0);
		addTest("ramRead", 24'h000500, 1'b0, 16'h0, 3);
		addTest("ioWrite", 24'h500300, 1'b1, 16'h1234, 0);
		addTest("ioRead", 24'h500300, 1'b0, 16'h0, 1);
		addTest("romWrite", 24'h400200, 1'b1, 16'hBEEF, 0);
		addTest("romRead", 24'h400200, 1'b0, 16'h0, 0);
		addTest("vidSnoop3", 24'h3F3000, 1'b1, 16'h0F0F, 0);
		addTest("vidSnoopE", 24'h3FE000, 1'b1, 16'h00FF, 0);
		addTest("sndSnoopA1", 24'h3FA100, 1'b1, 16'h5555, 0);
		addTest("sndSnoopFD", 24'h3FFD00, 1'b1, 16'hAAAA, 0);
		addTest("noSnoop", 24'h3F0000, 1'b1, 16'h7777, 0);
		addTest("iackRead", 24'hFF0000, 1'b0, 16'h0, 0);
		for (int i = 0; i < 6; i++) begin
			r = $random(seed);
			d = $random(seed);
			a = {2'b00, r[21:8], 8'h00};  // anywhere in RAM
			addTest($sformatf("rndWrite%0d", i), a, 1'b1, d[15:0], r[2:0]);
			r = $random(seed);
			addTest($sformatf("rndRead%0d", i), a, 1'b0, 16'h0, r[2:0]);
		end

		repeat (10) @(posedge CLK);
		arstN <= 1'b1;
		foreach (tests[i]) begin
			if (!timedOut)
				runTest(tests[i]);
		end
		repeat (2) @(posedge CLK);
		failCount += dut_i.props_i.assertFails;
		$display("tests passed %0d failed %0d", passCount, failCount);
		if (failCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: files.f
design/busPkg.sv
design/cycleFront.sv
design/chipSelect.sv
design/targetPort.sv
design/respMerge.sv
design/busGlue.sv
test/busGlue_props.sv
test/busGlue_tb.sv
